// ==== Makefile ====
TOOL      = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = tb_nvme_reg
FILE_LIST = build.f

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILE_LIST)
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir

// ==== build.f ====
source/nvme_reg_pkg.sv
source/mreq_decoder.sv
source/ctrl_regs.sv
source/queue_doorbells.sv
source/nvme_reg_top.sv
tests/nvme_reg_chk.sv
tests/tb_nvme_reg.sv

// ==== source/ctrl_regs.sv ====
`timescale 1ns/1ps

module ctrl_regs (
	input  logic                    pcie_user_clk,
	input  logic                    w_cq_rst_n,
	input  logic                    wr_reg,
	input  nvme_reg_pkg::reg_idx_t  reg_idx,
	input  logic                    lo_en,
	input  logic                    hi_en,
	input  nvme_reg_pkg::reg_data_t wr_data,
	input  logic                    nvme_csts_rdy,
	input  logic [1:0]              nvme_csts_shst,
	output nvme_reg_pkg::reg_data_t reg_rd_data,
	output logic                    nvme_cc_en,
	output logic [1:0]              nvme_cc_shn,
	output logic                    nvme_intms_ivms,
	output logic                    nvme_intmc_ivmc,
	output nvme_reg_pkg::qbase_t    admin_sq_bs_addr,
	output nvme_reg_pkg::qbase_t    admin_cq_bs_addr,
	output nvme_reg_pkg::qptr_t     admin_sq_size,
	output nvme_reg_pkg::qptr_t     admin_cq_size
);
	import nvme_reg_pkg::*;

	logic wr_lo;
	logic wr_hi;

	assign wr_lo = wr_reg & lo_en;
	assign wr_hi = wr_reg & hi_en;

	// Write data for either dword sits in bits 31 to 0
	always_ff @(posedge pcie_user_clk or negedge w_cq_rst_n) begin
		if (!w_cq_rst_n) begin
			nvme_cc_en <= 1'b0;
			nvme_cc_shn <= 2'b00;
			admin_sq_size <= '0;
			admin_cq_size <= '0;
			admin_sq_bs_addr <= '0;
			admin_cq_bs_addr <= '0;
		end else begin
			if (wr_lo) begin
				case (reg_idx)
					reg_idx_asq: admin_sq_bs_addr[29:0] <= wr_data[31:2];
					reg_idx_acq: admin_cq_bs_addr[29:0] <= wr_data[31:2];
					default: ;
				endcase
			end
			if (wr_hi) begin
				case (reg_idx)
					reg_idx_cc: begin
						nvme_cc_shn <= wr_data[15:14];
						nvme_cc_en <= wr_data[0];
					end
					reg_idx_aqa: begin
						admin_cq_size <= wr_data[23:16];
						admin_sq_size <= wr_data[7:0];
					end
					reg_idx_asq: admin_sq_bs_addr[45:30] <= wr_data[15:0];
					reg_idx_acq: admin_cq_bs_addr[45:30] <= wr_data[15:0];
					default: ;
				endcase
			end
		end
	end

	// One-cycle mask pulses
	always_ff @(posedge pcie_user_clk or negedge w_cq_rst_n) begin
		if (!w_cq_rst_n) begin
			nvme_intms_ivms <= 1'b0;
			nvme_intmc_ivmc <= 1'b0;
		end else begin
			nvme_intms_ivms <= wr_hi & (reg_idx == reg_idx_intms) & wr_data[0];
			nvme_intmc_ivmc <= wr_lo & (reg_idx == reg_idx_intmc) & wr_data[0];
		end
	end

	always_comb begin
		case (reg_idx)
			reg_idx_cap:  reg_rd_data = cap_value;
			reg_idx_vs:   reg_rd_data = vs_value;
			reg_idx_cc:   reg_rd_data = {16'd0, nvme_cc_shn, 13'd0, nvme_cc_en, 32'd0};
			reg_idx_csts: reg_rd_data = {28'd0, nvme_csts_shst, 1'b0, nvme_csts_rdy, 32'd0};
			reg_idx_aqa:  reg_rd_data = {8'd0, admin_cq_size, 8'd0, admin_sq_size, 32'd0};
			reg_idx_asq:  reg_rd_data = {16'd0, admin_sq_bs_addr, 2'b00};
			reg_idx_acq:  reg_rd_data = {16'd0, admin_cq_bs_addr, 2'b00};
			default:      reg_rd_data = '0;
		endcase
	end

endmodule

// ==== source/mreq_decoder.sv ====
`timescale 1ns/1ps

module mreq_decoder (
	input  logic                     pcie_user_clk,
	input  logic                     w_cq_rst_n,
	output logic                     mreq_fifo_rd_en,
	input  nvme_reg_pkg::mreq_word_t mreq_fifo_rd_data,
	input  logic                     mreq_fifo_empty_n,
	output logic                     tx_cpld_req,
	output logic [7:0]               tx_cpld_tag,
	output logic [15:0]              tx_cpld_req_id,
	output logic [10:0]              tx_cpld_len,
	output logic [6:0]               tx_cpld_laddr,
	output nvme_reg_pkg::reg_data_t  tx_cpld_data,
	input  logic                     tx_cpld_req_ack,
	input  nvme_reg_pkg::reg_data_t  reg_rd_data,
	input  nvme_reg_pkg::reg_data_t  db_rd_data,
	output logic                     wr_reg,
	output logic                     wr_doorbell,
	output nvme_reg_pkg::reg_idx_t   reg_idx,
	output logic                     lo_en,
	output logic                     hi_en,
	output nvme_reg_pkg::reg_data_t  wr_data
);
	import nvme_reg_pkg::*;

	mreq_state_t cur_state;
	mreq_state_t next_state;

	logic [31:0] head0;
	logic [31:0] head2;
	logic [31:0] head3;

	logic [3:0]  head_fmt;
	logic [1:0]  head_len; // Only 1 or 2 dwords are served
	logic [15:0] head_req_id;
	logic [7:0]  head_tag;
	logic [12:2] mreq_addr;
	reg_data_t   rd_data;
	logic        addr_in_regs;

	assign head0 = mreq_fifo_rd_data[31:0];
	assign head2 = mreq_fifo_rd_data[95:64];
	assign head3 = mreq_fifo_rd_data[127:96];

	always_ff @(posedge pcie_user_clk or negedge w_cq_rst_n) begin
		if (!w_cq_rst_n)
			cur_state <= idle;
		else
			cur_state <= next_state;
	end

	always_comb begin
		case (cur_state)
			idle:     next_state = mreq_fifo_empty_n ? rd_head : idle;
			rd_head:  next_state = addr;
			addr:     next_state = (head_fmt == fmt_mem_write) ? mwr : mrd;
			mwr:      next_state = idle;
			mrd:      next_state = cpld_req;
			cpld_req: next_state = cpld_ack;
			cpld_ack: next_state = tx_cpld_req_ack ? idle : cpld_ack;
			default:  next_state = idle;
		endcase
	end

	// Request fields, held until the next pop
	always_ff @(posedge pcie_user_clk) begin
		if (cur_state == rd_head) begin
			head_fmt <= head2[14:11];
			head_len <= head2[1:0];
			head_req_id <= head2[31:16];
			head_tag <= head3[7:0];
			mreq_addr <= head0[12:2];
			wr_data <= mreq_fifo_rd_data[191:128];
		end
	end

	always_ff @(posedge pcie_user_clk) begin
		if (cur_state == addr) begin
			lo_en <= ~mreq_addr[2] & (mreq_addr[11:7] == 5'd0);
			hi_en <= (mreq_addr[2] | head_len[1]) & (mreq_addr[11:7] == 5'd0);
		end
	end

	assign addr_in_regs = ~mreq_addr[12]; // Doorbells live at 0x1000 and up

	always_ff @(posedge pcie_user_clk) begin
		if (cur_state == mrd) begin
			if (lo_en | hi_en)
				rd_data <= addr_in_regs ? reg_rd_data : db_rd_data;
			else
				rd_data <= '0;
		end
	end

	assign mreq_fifo_rd_en = (cur_state == rd_head); // Pop and capture
	assign wr_reg = (cur_state == mwr) & addr_in_regs;
	assign wr_doorbell = (cur_state == mwr) & ~addr_in_regs;
	assign reg_idx = mreq_addr[6:3];

	assign tx_cpld_req = (cur_state == cpld_req);
	assign tx_cpld_tag = head_tag;
	assign tx_cpld_req_id = head_req_id;
	assign tx_cpld_len = {9'd0, head_len};
	assign tx_cpld_laddr = {mreq_addr[6:2], 2'b00};

	// Upper dword moves down for a read at +4
	assign tx_cpld_data = mreq_addr[2] ? {32'd0, rd_data[63:32]} : rd_data;

endmodule

// ==== source/nvme_reg_pkg.sv ====
package nvme_reg_pkg;

	localparam int addr_width = 48; // PCIe address bits
	localparam int num_queues = 9; // Admin plus eight I/O queues

	typedef logic [7:0] qptr_t;
	typedef logic [addr_width-3:0] qbase_t; // Dword address
	typedef logic [63:0] reg_data_t;
	typedef logic [3:0] reg_idx_t; // Address bits 6 to 3
	typedef logic [191:0] mreq_word_t; // Header dwords 0 to 3, data on top

	// Register offsets in 8-byte steps
	localparam reg_idx_t reg_idx_cap = 4'h0;
	localparam reg_idx_t reg_idx_vs = 4'h1;
	localparam reg_idx_t reg_idx_intms = 4'h1; // Upper dword of VS word
	localparam reg_idx_t reg_idx_intmc = 4'h2;
	localparam reg_idx_t reg_idx_cc = 4'h2; // Upper dword of INTMC word
	localparam reg_idx_t reg_idx_csts = 4'h3;
	localparam reg_idx_t reg_idx_aqa = 4'h4;
	localparam reg_idx_t reg_idx_asq = 4'h5;
	localparam reg_idx_t reg_idx_acq = 4'h6;

	localparam logic [3:0] fmt_mem_write = 4'b0001;

	localparam logic [15:0] cap_mqes = 16'h00ff; // Zero based, 256 entries
	localparam logic cap_cqr = 1'b1; // Contiguous queues only
	localparam logic [1:0] cap_ams = 2'b00;
	localparam logic [7:0] cap_to = 8'h10; // Ready timeout, 500 ms units
	localparam logic [3:0] cap_dstrd = 4'h0;
	localparam logic [7:0] cap_css = 8'h01; // NVM command set
	localparam logic [3:0] cap_mpsmin = 4'h0; // 4 KiB pages
	localparam logic [3:0] cap_mpsmax = 4'h0;

	localparam reg_data_t cap_value = {
		8'h00, cap_mpsmax, cap_mpsmin, 3'h0, cap_css, 1'b0, cap_dstrd,
		cap_to, 5'h00, cap_ams, cap_cqr, cap_mqes
	};

	localparam logic [15:0] vs_mjr = 16'h0001;
	localparam logic [7:0] vs_mnr = 8'h01;

	// INTMS reads back as zero in the upper dword
	localparam reg_data_t vs_value = {32'h0, vs_mjr, vs_mnr, 8'h00};

	typedef enum logic [6:0] {
		idle     = 7'b0000001,
		rd_head  = 7'b0000010,
		addr     = 7'b0000100,
		mwr      = 7'b0001000,
		mrd      = 7'b0010000,
		cpld_req = 7'b0100000,
		cpld_ack = 7'b1000000
	} mreq_state_t;

endpackage

// ==== source/nvme_reg_top.sv ====
`timescale 1ns/1ps

module nvme_reg_top (
	input  logic                     pcie_user_clk,
	input  logic                     w_cq_rst_n,
	output logic                     mreq_fifo_rd_en,
	input  nvme_reg_pkg::mreq_word_t mreq_fifo_rd_data,
	input  logic                     mreq_fifo_empty_n,
	output logic                     tx_cpld_req,
	output logic [7:0]               tx_cpld_tag,
	output logic [15:0]              tx_cpld_req_id,
	output logic [10:0]              tx_cpld_len,
	output logic [6:0]               tx_cpld_laddr,
	output nvme_reg_pkg::reg_data_t  tx_cpld_data,
	input  logic                     tx_cpld_req_ack,
	output logic                     nvme_cc_en,
	output logic [1:0]               nvme_cc_shn,
	input  logic                     nvme_csts_rdy,
	input  logic [1:0]               nvme_csts_shst,
	output logic                     nvme_intms_ivms,
	output logic                     nvme_intmc_ivmc,
	output nvme_reg_pkg::qbase_t     admin_sq_bs_addr,
	output nvme_reg_pkg::qbase_t     admin_cq_bs_addr,
	output nvme_reg_pkg::qptr_t      admin_sq_size,
	output nvme_reg_pkg::qptr_t      admin_cq_size,
	output nvme_reg_pkg::qptr_t [nvme_reg_pkg::num_queues-1:0] sq_tail_ptr,
	output nvme_reg_pkg::qptr_t [nvme_reg_pkg::num_queues-1:0] cq_head_ptr,
	output logic [nvme_reg_pkg::num_queues-1:0] cq_head_update
);
	import nvme_reg_pkg::*;

	logic      wr_reg;
	logic      wr_doorbell;
	reg_idx_t  reg_idx;
	logic      lo_en;
	logic      hi_en;
	reg_data_t wr_data;
	reg_data_t reg_rd_data;
	reg_data_t db_rd_data;

	mreq_decoder u_decoder (
		.pcie_user_clk     (pcie_user_clk),
		.w_cq_rst_n        (w_cq_rst_n),
		.mreq_fifo_rd_en   (mreq_fifo_rd_en),
		.mreq_fifo_rd_data (mreq_fifo_rd_data),
		.mreq_fifo_empty_n (mreq_fifo_empty_n),
		.tx_cpld_req       (tx_cpld_req),
		.tx_cpld_tag       (tx_cpld_tag),
		.tx_cpld_req_id    (tx_cpld_req_id),
		.tx_cpld_len       (tx_cpld_len),
		.tx_cpld_laddr     (tx_cpld_laddr),
		.tx_cpld_data      (tx_cpld_data),
		.tx_cpld_req_ack   (tx_cpld_req_ack),
		.reg_rd_data       (reg_rd_data),
		.db_rd_data        (db_rd_data),
		.wr_reg            (wr_reg),
		.wr_doorbell       (wr_doorbell),
		.reg_idx           (reg_idx),
		.lo_en             (lo_en),
		.hi_en             (hi_en),
		.wr_data           (wr_data)
	);

	ctrl_regs u_ctrl_regs (
		.pcie_user_clk    (pcie_user_clk),
		.w_cq_rst_n       (w_cq_rst_n),
		.wr_reg           (wr_reg),
		.reg_idx          (reg_idx),
		.lo_en            (lo_en),
		.hi_en            (hi_en),
		.wr_data          (wr_data),
		.nvme_csts_rdy    (nvme_csts_rdy),
		.nvme_csts_shst   (nvme_csts_shst),
		.reg_rd_data      (reg_rd_data),
		.nvme_cc_en       (nvme_cc_en),
		.nvme_cc_shn      (nvme_cc_shn),
		.nvme_intms_ivms  (nvme_intms_ivms),
		.nvme_intmc_ivmc  (nvme_intmc_ivmc),
		.admin_sq_bs_addr (admin_sq_bs_addr),
		.admin_cq_bs_addr (admin_cq_bs_addr),
		.admin_sq_size    (admin_sq_size),
		.admin_cq_size    (admin_cq_size)
	);

	queue_doorbells u_doorbells (
		.pcie_user_clk  (pcie_user_clk),
		.w_cq_rst_n     (w_cq_rst_n),
		.wr_doorbell    (wr_doorbell),
		.reg_idx        (reg_idx),
		.lo_en          (lo_en),
		.hi_en          (hi_en),
		.wr_data        (wr_data),
		.db_rd_data     (db_rd_data),
		.sq_tail_ptr    (sq_tail_ptr),
		.cq_head_ptr    (cq_head_ptr),
		.cq_head_update (cq_head_update)
	);

endmodule

// ==== source/queue_doorbells.sv ====
`timescale 1ns/1ps

module queue_doorbells (
	input  logic                    pcie_user_clk,
	input  logic                    w_cq_rst_n,
	input  logic                    wr_doorbell,
	input  nvme_reg_pkg::reg_idx_t  reg_idx,
	input  logic                    lo_en,
	input  logic                    hi_en,
	input  nvme_reg_pkg::reg_data_t wr_data,
	output nvme_reg_pkg::reg_data_t db_rd_data,
	output nvme_reg_pkg::qptr_t [nvme_reg_pkg::num_queues-1:0] sq_tail_ptr,
	output nvme_reg_pkg::qptr_t [nvme_reg_pkg::num_queues-1:0] cq_head_ptr,
	output logic [nvme_reg_pkg::num_queues-1:0] cq_head_update
);
	import nvme_reg_pkg::*;

	for (genvar q = 0; q < num_queues; q++) begin : g_queue
		logic idx_hit;

		assign idx_hit = wr_doorbell & (reg_idx == reg_idx_t'(q));

		always_ff @(posedge pcie_user_clk or negedge w_cq_rst_n) begin
			if (!w_cq_rst_n) begin
				sq_tail_ptr[q] <= '0;
				cq_head_ptr[q] <= '0;
				cq_head_update[q] <= 1'b0;
			end else begin
				if (idx_hit & lo_en)
					sq_tail_ptr[q] <= wr_data[7:0]; // SQ tail at +0
				if (idx_hit & hi_en)
					cq_head_ptr[q] <= wr_data[7:0]; // CQ head at +4
				cq_head_update[q] <= idx_hit & hi_en;
			end
		end
	end

	always_comb begin
		if (reg_idx < reg_idx_t'(num_queues))
			db_rd_data = {24'd0, cq_head_ptr[reg_idx], 24'd0, sq_tail_ptr[reg_idx]};
		else
			db_rd_data = '0;
	end

endmodule

// ==== tests/nvme_reg_chk.sv ====
`timescale 1ns/1ps

module nvme_reg_chk (
	input logic                    pcie_user_clk,
	input logic                    w_cq_rst_n,
	input logic                    mreq_fifo_rd_en,
	input logic                    tx_cpld_req,
	input logic                    tx_cpld_req_ack,
	input logic [7:0]              tx_cpld_tag,
	input logic [15:0]             tx_cpld_req_id,
	input logic [10:0]             tx_cpld_len,
	input logic [6:0]              tx_cpld_laddr,
	input nvme_reg_pkg::reg_data_t tx_cpld_data,
	input logic [nvme_reg_pkg::num_queues-1:0] cq_head_update
);
	logic waiting; // Between request and acknowledge

	always_ff @(posedge pcie_user_clk or negedge w_cq_rst_n) begin
		if (!w_cq_rst_n)
			waiting <= 1'b0;
		else if (tx_cpld_req)
			waiting <= 1'b1;
		else if (tx_cpld_req_ack)
			waiting <= 1'b0;
	end

	assert property (@(posedge pcie_user_clk) disable iff (!w_cq_rst_n)
		mreq_fifo_rd_en |=> !mreq_fifo_rd_en)
		else $error("FIFO read enable longer than one cycle");

	assert property (@(posedge pcie_user_clk) disable iff (!w_cq_rst_n)
		tx_cpld_req |=> !tx_cpld_req)
		else $error("Completion request longer than one cycle");

	assert property (@(posedge pcie_user_clk) disable iff (!w_cq_rst_n)
		(waiting || tx_cpld_req) |-> !mreq_fifo_rd_en)
		else $error("FIFO read while a completion is pending");

	assert property (@(posedge pcie_user_clk) disable iff (!w_cq_rst_n)
		(tx_cpld_req || (waiting && !tx_cpld_req_ack)) |=>
		$stable({tx_cpld_tag, tx_cpld_req_id, tx_cpld_len, tx_cpld_laddr, tx_cpld_data}))
		else $error("Completion outputs changed before the acknowledge");

	assert property (@(posedge pcie_user_clk) disable iff (!w_cq_rst_n)
		$onehot0(cq_head_update))
		else $error("More than one head update bit set");

endmodule

bind nvme_reg_top nvme_reg_chk u_chk (
	.pcie_user_clk   (pcie_user_clk),
	.w_cq_rst_n      (w_cq_rst_n),
	.mreq_fifo_rd_en (mreq_fifo_rd_en),
	.tx_cpld_req     (tx_cpld_req),
	.tx_cpld_req_ack (tx_cpld_req_ack),
	.tx_cpld_tag     (tx_cpld_tag),
	.tx_cpld_req_id  (tx_cpld_req_id),
	.tx_cpld_len     (tx_cpld_len),
	.tx_cpld_laddr   (tx_cpld_laddr),
	.tx_cpld_data    (tx_cpld_data),
	.cq_head_update  (cq_head_update)
);

// ==== tests/tb_nvme_reg.sv ====
`timescale 1ns/1ps

module tb_nvme_reg;
	import nvme_reg_pkg::*;

	localparam int max_wait = 200; // Cycles per wait

	logic pcie_user_clk;
	logic w_cq_rst_n;
	logic mreq_fifo_rd_en;
	mreq_word_t mreq_fifo_rd_data;
	logic mreq_fifo_empty_n;
	logic tx_cpld_req;
	logic [7:0] tx_cpld_tag;
	logic [15:0] tx_cpld_req_id;
	logic [10:0] tx_cpld_len;
	logic [6:0] tx_cpld_laddr;
	reg_data_t tx_cpld_data;
	logic tx_cpld_req_ack;
	logic nvme_cc_en;
	logic [1:0] nvme_cc_shn;
	logic nvme_csts_rdy;
	logic [1:0] nvme_csts_shst;
	logic nvme_intms_ivms;
	logic nvme_intmc_ivmc;
	qbase_t admin_sq_bs_addr;
	qbase_t admin_cq_bs_addr;
	qptr_t admin_sq_size;
	qptr_t admin_cq_size;
	qptr_t [num_queues-1:0] sq_tail_ptr;
	qptr_t [num_queues-1:0] cq_head_ptr;
	logic [num_queues-1:0] cq_head_update;

	logic [15:0] lfsr_state = 16'd99;
	logic [7:0] got_tag;
	logic [15:0] got_req_id;
	logic [10:0] got_len;
	logic [6:0] got_laddr;
	reg_data_t got_data;
	logic [num_queues+1:0] pulse_snap; // {ivms, ivmc, update}
	logic [num_queues+1:0] pulse_after;
	qptr_t exp_sq [num_queues];
	qptr_t exp_cq [num_queues];

	nvme_reg_top u_dut (.*);

	always #2 pcie_user_clk = ~pcie_user_clk;

	function automatic logic [7:0] rand_bits(input int n);
		logic [7:0] r;
		logic fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
			r = {r[6:0], lfsr_state[15]};
			lfsr_state = {lfsr_state[14:0], fb};
		end
		return r;
	endfunction

	// CAP field positions of the NVMe register map
	function automatic reg_data_t cap_from_fields();
		reg_data_t c;
		c = '0;
		c[15:0] = cap_mqes;
		c[16] = cap_cqr;
		c[18:17] = cap_ams;
		c[31:24] = cap_to;
		c[35:32] = cap_dstrd;
		c[44:37] = cap_css;
		c[51:48] = cap_mpsmin;
		c[55:52] = cap_mpsmax;
		return c;
	endfunction

	function automatic mreq_word_t build_word(input bit wr, input logic [12:0] a,
			input logic [1:0] len, input logic [15:0] rid, input logic [7:0] tag,
			input reg_data_t data);
		mreq_word_t w;
		w = '0;
		w[12:2] = a[12:2];
		w[78:75] = wr ? 4'b0001 : 4'b0000; // Format field
		w[65:64] = len;
		w[95:80] = rid;
		w[103:96] = tag;
		w[191:128] = data;
		return w;
	endfunction

	task automatic check_value(input string name, input logic [127:0] exp,
			input logic [127:0] act);
		assert (exp === act)
		else begin
			$display("[FAIL] %s expected %h actual %h", name, exp, act);
			$display("CHECKS FAILED");
			$fatal(1);
		end
	endtask

	task automatic report_timeout(input string what);
		$display("Timed out waiting for %s", what);
		$display("CHECKS FAILED");
		$fatal(1);
	endtask

	// Present a word and return at the edge that pops it
	task automatic pop_word(input mreq_word_t w, input bit more);
		int n;
		@(posedge pcie_user_clk);
		mreq_fifo_rd_data <= w;
		mreq_fifo_empty_n <= 1'b1;
		n = 0;
		do begin
			@(negedge pcie_user_clk);
			n++;
			if (n > max_wait)
				report_timeout("a FIFO read");
		end while (!mreq_fifo_rd_en);
		@(posedge pcie_user_clk);
		if (!more)
			mreq_fifo_empty_n <= 1'b0;
	endtask

	task automatic get_completion();
		int n;
		int delay;
		n = 0;
		do begin
			@(negedge pcie_user_clk);
			n++;
			if (n > max_wait)
				report_timeout("a completion request");
		end while (!tx_cpld_req);
		got_tag = tx_cpld_tag;
		got_req_id = tx_cpld_req_id;
		got_len = tx_cpld_len;
		got_laddr = tx_cpld_laddr;
		got_data = tx_cpld_data;
		delay = int'(rand_bits(3));
		repeat (delay) @(posedge pcie_user_clk);
		@(posedge pcie_user_clk);
		tx_cpld_req_ack <= 1'b1;
		@(posedge pcie_user_clk);
		tx_cpld_req_ack <= 1'b0;
	endtask

	task automatic write_req(input logic [12:0] a, input logic [1:0] len, input reg_data_t d);
		pop_word(build_word(1'b1, a, len, 16'h0, 8'h0, d), 1'b0);
		repeat (3) @(negedge pcie_user_clk); // Outputs change 3 cycles after the pop
		pulse_snap = {nvme_intms_ivms, nvme_intmc_ivmc, cq_head_update};
		@(negedge pcie_user_clk);
		pulse_after = {nvme_intms_ivms, nvme_intmc_ivmc, cq_head_update};
	endtask

	task automatic read_req(input logic [12:0] a, input logic [1:0] len,
			input logic [7:0] tag, input logic [15:0] rid);
		pop_word(build_word(1'b0, a, len, rid, tag, 64'h0), 1'b0);
		get_completion();
	endtask

	initial begin
		int q;
		logic [7:0] v;
		pcie_user_clk = 1'b0;
		w_cq_rst_n = 1'b0;
		mreq_fifo_rd_data = '0;
		mreq_fifo_empty_n = 1'b0;
		tx_cpld_req_ack = 1'b0;
		nvme_csts_rdy = 1'b0;
		nvme_csts_shst = 2'b00;
		for (int i = 0; i < num_queues; i++) begin
			exp_sq[i] = '0;
			exp_cq[i] = '0;
		end
		repeat (5) @(posedge pcie_user_clk);
		w_cq_rst_n <= 1'b1;
		@(negedge pcie_user_clk);

		check_value("reset controls", 0, 128'({mreq_fifo_rd_en, tx_cpld_req, nvme_cc_en,
			nvme_intms_ivms, nvme_intmc_ivmc, cq_head_update}));
		check_value("reset sq tails", 0, 128'(sq_tail_ptr));
		check_value("reset cq heads", 0, 128'(cq_head_ptr));
		check_value("reset admin", 0, 128'({admin_sq_bs_addr, admin_cq_bs_addr,
			admin_sq_size, admin_cq_size}));

		write_req(13'h014, 2'd1, 64'h4001); // CC shn 01 and en 1
		check_value("cc en", 1, 128'(nvme_cc_en));
		check_value("cc shn", 128'(2'b01), 128'(nvme_cc_shn));
		read_req(13'h014, 2'd1, 8'h5c, 16'hbeef);
		check_value("cc data", 128'(64'h4001), 128'(got_data));
		check_value("cc tag", 128'(8'h5c), 128'(got_tag));
		check_value("cc req id", 128'(16'hbeef), 128'(got_req_id));
		check_value("cc laddr", 128'(7'h14), 128'(got_laddr));
		check_value("cc len", 128'(11'd1), 128'(got_len));

		write_req(13'h024, 2'd1, 64'h001f_003f);
		check_value("aqa sq size", 128'(8'h3f), 128'(admin_sq_size));
		check_value("aqa cq size", 128'(8'h1f), 128'(admin_cq_size));
		write_req(13'h028, 2'd1, 64'h5678_9000);
		write_req(13'h02c, 2'd1, 64'h1234);
		check_value("asq base", 128'(48'h1234_5678_9000 >> 2), 128'(admin_sq_bs_addr));
		write_req(13'h030, 2'd1, 64'hcafe_f004);
		write_req(13'h034, 2'd1, 64'h00ab);
		check_value("acq base", 128'(48'h00ab_cafe_f004 >> 2), 128'(admin_cq_bs_addr));
		read_req(13'h028, 2'd2, 8'h01, 16'h0100);
		check_value("asq read", 128'(64'h1234_5678_9000), 128'(got_data));
		read_req(13'h000, 2'd2, 8'h02, 16'h0100);
		check_value("cap read", 128'(cap_from_fields()), 128'(got_data));
		@(posedge pcie_user_clk);
		nvme_csts_rdy <= 1'b1;
		nvme_csts_shst <= 2'b10;
		read_req(13'h01c, 2'd1, 8'h03, 16'h0100);
		check_value("csts read", 128'(64'h9), 128'(got_data));

		write_req(13'h1018, 2'd1, 64'h5a);
		exp_sq[3] = 8'h5a;
		check_value("sq tail", 128'({40'h0, 8'h5a, 24'h0}), 128'(sq_tail_ptr));
		write_req(13'h101c, 2'd1, 64'hc3);
		exp_cq[3] = 8'hc3;
		check_value("cq head", 128'({40'h0, 8'hc3, 24'h0}), 128'(cq_head_ptr));
		check_value("update pulse", 128'(9'b000001000), 128'(pulse_snap[num_queues-1:0]));
		check_value("update end", 0, 128'(pulse_after));
		read_req(13'h1018, 2'd2, 8'h04, 16'h0200);
		check_value("doorbell read", 128'(64'h0000_00c3_0000_005a), 128'(got_data));

		write_req(13'h00c, 2'd1, 64'h1);
		check_value("intms pulse", 128'({2'b10, 9'h0}), 128'(pulse_snap));
		check_value("intms end", 0, 128'(pulse_after));
		write_req(13'h00c, 2'd1, 64'h0);
		check_value("intms zero", 0, 128'(pulse_snap));
		write_req(13'h010, 2'd1, 64'h1);
		check_value("intmc pulse", 128'({2'b01, 9'h0}), 128'(pulse_snap));
		check_value("intmc end", 0, 128'(pulse_after));

		// Back-to-back words with random acknowledge delays
		for (int i = 0; i < 8; i++) begin
			q = i % num_queues;
			v = rand_bits(8);
			exp_sq[q] = v;
			pop_word(build_word(1'b1, 13'h1000 + 13'(q * 8), 2'd1, 16'h0, 8'h0, 64'(v)), 1'b1);
			pop_word(build_word(1'b0, 13'h1000 + 13'(q * 8), 2'd2, 16'h0300, 8'(i), 64'h0),
				i < 7);
			get_completion();
			check_value("stream tag", 128'(8'(i)), 128'(got_tag));
			check_value("stream data", 128'({24'h0, exp_cq[q], 24'h0, exp_sq[q]}),
				128'(got_data));
		end

		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule
